//--- build.f
hw/csr_map_pkg.sv
hw/exc_pkg.sv
hw/exc_state_regs.sv
hw/timer_unit.sv
hw/int_ctrl.sv
hw/csr_read_mux.sv
hw/csr_top.sv
verif/csr_properties.sv
verif/csr_tb.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
TOP       = csr_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+1000
PASS_TEXT = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator status is ignored, the log decides
run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/csr_trace.txt
# op name a b c d, all hex. W num mask value 0, R num expected 0 0, X/B ecode esubcode vaddr pc
# E 0 0 0 0 ertn, N entry 0 0 0, H has_int 0 0 0, Q num mask expected timeout
R crmd_reset 0 00000008 0 0
R tval_reset 42 ffffffff 0 0
H int_reset 0 0 0 0
W crmd_set 0 00000017 ffffffff 0
R crmd_set 0 0000001f 0 0
W crmd_clear 0 0000000b 00000000 0
R crmd_clear 0 00000014 0 0
W prmd_set 1 ffffffff 0000ffff 0
R prmd_set 1 00000007 0 0
W era_hi 6 ffff0000 12345678 0
R era_hi 6 12340000 0 0
W era_lo 6 0000ffff abcdefff 0
R era_lo 6 1234efff 0 0
W eentry_set c ffffffff 1c008abc 0
R eentry_set c 1c008a80 0 0
N entry_set 1c008a80 0 0 0
W ecfg_all 4 ffffffff ffffffff 0
R ecfg_all 4 00001bff 0 0
W ecfg_low 4 00000fff 00000000 0
R ecfg_low 4 00001000 0 0
W estat_swi 5 ffffffff ffffffff 0
R estat_swi 5 00000003 0 0
W estat_swi0 5 00000001 00000000 0
R estat_swi0 5 00000002 0 0
R unknown_num 3 00000000 0 0
R ticlr_read 44 00000000 0 0
H int_lie_off 0 0 0 0
W ecfg_lie1 4 00000002 ffffffff 0
H int_swi1 1 0 0 0
W crmd_ie_off 0 00000004 00000000 0
H int_ie_off 0 0 0 0
W crmd_ie_on 0 00000004 00000004 0
W estat_swi_swap 5 00000003 00000001 0
H int_swi0_masked 0 0 0 0
W ecfg_lie0 4 00000001 00000001 0
H int_swi0 1 0 0 0
W estat_swi_off 5 00000003 00000000 0
H int_swi_off 0 0 0 0
W crmd_plv3 0 00000003 00000003 0
W prmd_clear 1 00000007 00000000 0
X exc_ale 09 000 80001234 1c000100
R ale_crmd 0 00000010 0 0
R ale_prmd 1 00000007 0 0
R ale_era 6 1c000100 0 0
R ale_estat 5 00090000 0 0
R ale_badv 7 80001234 0 0
N ale_entry 1c008a80 0 0 0
W crmd_plv1 0 00000007 00000001 0
X exc_adef 08 000 90000000 1c000200
R adef_prmd 1 00000001 0 0
R adef_estat 5 00080000 0 0
R adef_badv 7 1c000200 0 0
X exc_adem 08 001 a0000040 1c000300
R adem_estat 5 00480000 0 0
R adem_badv 7 a0000040 0 0
X exc_sys 0b 000 ffffffff 1c000400
R sys_era 6 1c000400 0 0
R sys_badv 7 a0000040 0 0
W prmd_ret 1 00000007 00000006 0
E ertn 0 0 0 0
R ertn_crmd 0 00000016 0 0
B exc_over_ertn 0b 000 00000000 1c000500
R both_crmd 0 00000010 0 0
R both_prmd 1 00000006 0 0
R both_era 6 1c000500 0 0
W tcfg_oneshot 41 ffffffff 00000009 0
R tval_k0 42 00000008 0 0
R tval_k1 42 00000007 0 0
R tval_k2 42 00000006 0 0
Q oneshot_irq 5 00000800 00000800 20
R tval_idle 42 ffffffff 0 0
R tcfg_read 41 00000009 0 0
R oneshot_estat 5 000b0800 0 0
W ecfg_lie11 4 00000800 00000800 0
H int_timer_ie_off 0 0 0 0
W crmd_ie_timer 0 00000004 00000004 0
H int_timer 1 0 0 0
W ticlr_clear 44 00000001 00000001 0
R ticlr_estat 5 000b0000 0 0
H int_timer_clear 0 0 0 0
W tcfg_periodic 41 ffffffff 00000007 0
R ptval_k0 42 00000004 0 0
R ptval_k1 42 00000003 0 0
R ptval_k2 42 00000002 0 0
R ptval_k3 42 00000001 0 0
R ptval_k4 42 00000000 0 0
R ptval_reload 42 00000004 0 0
R periodic_irq 5 000b0800 0 0
W periodic_clear 44 00000001 00000001 0
R periodic_cleared 5 000b0000 0 0
Q periodic_irq_again 5 00000800 00000800 20
H int_periodic 1 0 0 0

//--- verif/csr_tb.sv
`timescale 1ns/1ps

module csr_tb
    import csr_map_pkg::*;
    import exc_pkg::*;
();

    typedef logic [8*24-1:0] test_name_t;

    localparam int MAX_TRACE_LINES = 512;

    logic        clk;
    logic        reset;
    csr_access_t access;
    logic        ertn_flush;
    wb_exc_t     wb_exc;
    csr_word_t   rvalue;
    csr_word_t   ex_entry;
    logic        has_int;

    int check_count;
    int error_count;

    csr_top u_csr_top (
        .clk        (clk),
        .reset      (reset),
        .access     (access),
        .ertn_flush (ertn_flush),
        .wb_exc     (wb_exc),
        .rvalue     (rvalue),
        .ex_entry   (ex_entry),
        .has_int    (has_int)
    );

    always #4 clk = ~clk;

    task automatic check_word(input test_name_t name, input csr_word_t expected,
                              input csr_word_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error %0s expected %08h actual %08h", name, expected, actual);
        end else begin
            $display("ok    %0s value %08h", name, actual);
        end
    endtask

    task automatic check_bit(input test_name_t name, input logic expected,
                             input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error %0s expected %0b actual %0b", name, expected, actual);
        end else begin
            $display("ok    %0s value %0b", name, actual);
        end
    endtask

    task automatic drive_idle();
        access     <= '{we: 1'b0, num: CSR_CRMD, wmask: '0, wvalue: '0};
        ertn_flush <= 1'b0;
        wb_exc     <= '0;
    endtask

    // one cycle per op, outputs sampled at the falling edge
    task automatic run_op(input logic [7:0] op, input test_name_t name,
                          input csr_word_t a, input csr_word_t b,
                          input csr_word_t c, input csr_word_t d);
        @(posedge clk);
        drive_idle();
        case (op)
            "W": access <= '{we: 1'b1, num: a[13:0], wmask: b, wvalue: c};
            "R": access <= '{we: 1'b0, num: a[13:0], wmask: '0, wvalue: '0};
            "X", "B": begin
                wb_exc     <= '{ex: 1'b1, ecode: a[5:0], esubcode: b[8:0], vaddr: c, pc: d};
                ertn_flush <= (op == "B");
            end
            "E": ertn_flush <= 1'b1;
            default: ;
        endcase
        @(negedge clk);
        case (op)
            "R": check_word(name, b, rvalue);
            "N": check_word(name, a, ex_entry);
            "H": check_bit(name, a[0], has_int);
            default: ;
        endcase
    endtask

    task automatic wait_for_field(input test_name_t name, input csr_num_t num,
                                  input csr_word_t mask, input csr_word_t expected,
                                  input int limit);
        int   cycles;
        logic hit;
        cycles = 0;
        hit = 1'b0;
        while (!hit && cycles < limit) begin
            @(posedge clk);
            drive_idle();
            access <= '{we: 1'b0, num: num, wmask: '0, wvalue: '0};
            @(negedge clk);
            hit = ((rvalue & mask) == expected);
            cycles++;
        end
        check_count++;
        if (hit) begin
            $display("ok    %0s after %0d cycles", name, cycles);
        end else begin
            error_count++;
            $display("timeout in %0s, field never reached %08h within %0d cycles",
                     name, expected, limit);
        end
    endtask

    task automatic run_trace(input int fd);
        logic [7:0] op;
        test_name_t name;
        csr_word_t  a;
        csr_word_t  b;
        csr_word_t  c;
        csr_word_t  d;
        string      rest;
        int         code;
        int         lines;
        logic       done;
        lines = 0;
        done = 1'b0;
        code = $fscanf(fd, " %c", op);
        while (code == 1 && !done && lines < MAX_TRACE_LINES) begin
            lines++;
            if (op == "#") begin
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%s %h %h %h %h", name, a, b, c, d);
                if (code != 5) begin
                    $display("trace line %0d is malformed, reading stopped", lines);
                    error_count++;
                    done = 1'b1;
                end else begin
                    case (op)
                        "W", "R", "X", "B", "E", "N", "H": run_op(op, name, a, b, c, d);
                        "Q": wait_for_field(name, a[13:0], b, c, int'(d));
                        default: begin
                            $display("unknown operation %c in trace line %0d", op, lines);
                            error_count++;
                        end
                    endcase
                end
            end
            code = $fscanf(fd, " %c", op);
        end
    endtask

    initial begin
        int fd;
        int assert_fails;
        clk         = 1'b0;
        reset       = 1'b1;
        access      = '0;
        ertn_flush  = 1'b0;
        wb_exc      = '0;
        check_count = 0;
        error_count = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        fd = $fopen("verif/csr_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file verif/csr_trace.txt");
            error_count++;
        end else begin
            run_trace(fd);
            $fclose(fd);
        end
        assert_fails = u_csr_top.u_csr_properties.violations;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- verif/csr_properties.sv
`timescale 1ns/1ps

module csr_properties
    import csr_map_pkg::*;
    import exc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  csr_access_t access,
    input  wb_exc_t     wb_exc,
    input  csr_word_t   rvalue,
    input  csr_word_t   ex_entry,
    input  logic        has_int,
    input  logic [1:0]  crmd_plv
);

    int reset_fails = 0;
    int entry_fails = 0;
    int plv_fails   = 0;
    int violations;

    logic reset_q;

    always_ff @(posedge clk) begin
        reset_q <= reset;
    end

    assign violations = reset_fails + entry_fails + plv_fails;

    // state is known from the second reset edge on
    no_int_in_reset: assert property (@(posedge clk) (reset && reset_q) |-> !has_int)
        else begin
            reset_fails++;
            $error("has_int high during reset");
        end

    // eentry is left alone by everything but its own csr write
    entry_matches_read: assert property (@(posedge clk) disable iff (reset)
        (access.num == CSR_EENTRY && !access.we) |=> (ex_entry == $past(rvalue)))
        else begin
            entry_fails++;
            $error("ex_entry differs from the EENTRY read value");
        end

    plv_cleared_on_exc: assert property (@(posedge clk) disable iff (reset)
        wb_exc.ex |=> (crmd_plv == 2'b00))
        else begin
            plv_fails++;
            $error("CRMD.PLV not zero after an exception");
        end

endmodule

bind csr_top csr_properties u_csr_properties (
    .clk      (clk),
    .reset    (reset),
    .access   (access),
    .wb_exc   (wb_exc),
    .rvalue   (rvalue),
    .ex_entry (ex_entry),
    .has_int  (has_int),
    .crmd_plv (crmd_plv)
);

//--- hw/csr_top.sv
`timescale 1ns/1ps

module csr_top
    import csr_map_pkg::*;
    import exc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  csr_access_t access,
    input  logic        ertn_flush,
    input  wb_exc_t     wb_exc,
    output csr_word_t   rvalue,
    output csr_word_t   ex_entry,
    output logic        has_int
);

    logic [1:0]  crmd_plv;
    logic [1:0]  prmd_pplv;
    logic        crmd_ie;
    logic        prmd_pie;
    logic [5:0]  crmd_mode;
    csr_word_t   era;
    csr_word_t   badv;
    logic [25:0] eentry_va;
    ecode_t      estat_ecode;
    esubcode_t   estat_esubcode;

    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    csr_word_t   tval;
    logic        timer_irq;

    logic [12:0] ecfg_lie;
    logic [12:0] estat_is;

    exc_state_regs u_exc_state_regs (
        .clk            (clk),
        .reset          (reset),
        .access         (access),
        .ertn_flush     (ertn_flush),
        .wb_exc         (wb_exc),
        .crmd_plv       (crmd_plv),
        .prmd_pplv      (prmd_pplv),
        .crmd_ie        (crmd_ie),
        .prmd_pie       (prmd_pie),
        .crmd_mode      (crmd_mode),
        .era            (era),
        .badv           (badv),
        .eentry_va      (eentry_va),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode)
    );

    timer_unit u_timer_unit (
        .clk           (clk),
        .reset         (reset),
        .access        (access),
        .tcfg_en       (tcfg_en),
        .tcfg_periodic (tcfg_periodic),
        .tcfg_initval  (tcfg_initval),
        .tval          (tval),
        .timer_irq     (timer_irq)
    );

    int_ctrl u_int_ctrl (
        .clk       (clk),
        .reset     (reset),
        .access    (access),
        .crmd_ie   (crmd_ie),
        .timer_irq (timer_irq),
        .ecfg_lie  (ecfg_lie),
        .estat_is  (estat_is),
        .has_int   (has_int)
    );

    csr_read_mux u_csr_read_mux (
        .num            (access.num),
        .crmd_plv       (crmd_plv),
        .crmd_ie        (crmd_ie),
        .crmd_mode      (crmd_mode),
        .prmd_pplv      (prmd_pplv),
        .prmd_pie       (prmd_pie),
        .era            (era),
        .badv           (badv),
        .eentry_va      (eentry_va),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode),
        .estat_is       (estat_is),
        .ecfg_lie       (ecfg_lie),
        .tcfg_en        (tcfg_en),
        .tcfg_periodic  (tcfg_periodic),
        .tcfg_initval   (tcfg_initval),
        .tval           (tval),
        .rvalue         (rvalue),
        .ex_entry       (ex_entry)
    );

endmodule

//--- hw/csr_read_mux.sv
`timescale 1ns/1ps

module csr_read_mux
    import csr_map_pkg::*;
(
    input  csr_num_t    num,
    input  logic [1:0]  crmd_plv,
    input  logic        crmd_ie,
    input  logic [5:0]  crmd_mode,
    input  logic [1:0]  prmd_pplv,
    input  logic        prmd_pie,
    input  csr_word_t   era,
    input  csr_word_t   badv,
    input  logic [25:0] eentry_va,
    input  logic [5:0]  estat_ecode,
    input  logic [8:0]  estat_esubcode,
    input  logic [12:0] estat_is,
    input  logic [12:0] ecfg_lie,
    input  logic        tcfg_en,
    input  logic        tcfg_periodic,
    input  logic [29:0] tcfg_initval,
    input  csr_word_t   tval,
    output csr_word_t   rvalue,
    output csr_word_t   ex_entry
);

    csr_word_t crmd_word;
    csr_word_t prmd_word;
    csr_word_t estat_word;
    csr_word_t ecfg_word;
    csr_word_t eentry_word;
    csr_word_t tcfg_word;

    always_comb begin
        crmd_word = '0;
        crmd_word[CRMD_PLV_HI:CRMD_PLV_LO]   = crmd_plv;
        crmd_word[CRMD_IE]                   = crmd_ie;
        crmd_word[CRMD_MODE_HI:CRMD_MODE_LO] = crmd_mode;

        prmd_word = '0;
        prmd_word[PRMD_PPLV_HI:PRMD_PPLV_LO] = prmd_pplv;
        prmd_word[PRMD_PIE]                  = prmd_pie;

        estat_word = '0;
        estat_word[ESTAT_IS_HI:0]                        = estat_is;
        estat_word[ESTAT_ECODE_HI:ESTAT_ECODE_LO]        = estat_ecode;
        estat_word[ESTAT_ESUBCODE_HI:ESTAT_ESUBCODE_LO]  = estat_esubcode;

        ecfg_word = '0;
        ecfg_word[ECFG_LIE_HI:0] = ecfg_lie;

        eentry_word = '0;
        eentry_word[31:EENTRY_VA_LO] = eentry_va;

        tcfg_word = '0;
        tcfg_word[TCFG_EN]                         = tcfg_en;
        tcfg_word[TCFG_PERIODIC]                   = tcfg_periodic;
        tcfg_word[TCFG_INITVAL_HI:TCFG_INITVAL_LO] = tcfg_initval;
    end

    always_comb begin
        case (num)
            CSR_CRMD:   rvalue = crmd_word;
            CSR_PRMD:   rvalue = prmd_word;
            CSR_ESTAT:  rvalue = estat_word;
            CSR_ERA:    rvalue = era;
            CSR_BADV:   rvalue = badv;
            CSR_EENTRY: rvalue = eentry_word;
            CSR_ECFG:   rvalue = ecfg_word;
            CSR_TCFG:   rvalue = tcfg_word;
            CSR_TVAL:   rvalue = tval;
            // clear bit is write-only
            CSR_TICLR:  rvalue = '0;
            default:    rvalue = '0;
        endcase
    end

    assign ex_entry = eentry_word;

endmodule

//--- hw/int_ctrl.sv
`timescale 1ns/1ps

module int_ctrl
    import csr_map_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  csr_access_t access,
    input  logic        crmd_ie,
    input  logic        timer_irq,
    output logic [12:0] ecfg_lie,
    output logic [12:0] estat_is,
    output logic        has_int
);

    logic      we_ecfg;
    logic      we_estat;
    logic [1:0] swi;
    csr_word_t ecfg_next;
    csr_word_t estat_next;

    assign we_ecfg  = access.we && (access.num == CSR_ECFG);
    assign we_estat = access.we && (access.num == CSR_ESTAT);

    assign ecfg_next = csr_masked({19'b0, ecfg_lie}, access.wmask, access.wvalue);
    assign estat_next = csr_masked({19'b0, estat_is}, access.wmask, access.wvalue);

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
            swi      <= 2'b0;
        end else begin
            if (we_ecfg) begin
                ecfg_lie <= ecfg_next[ECFG_LIE_HI:0] & ECFG_LIE_WRITABLE;
            end
            // only the software bits of is take a csr write
            if (we_estat) begin
                swi <= estat_next[ESTAT_SWI_HI:ESTAT_SWI_LO];
            end
        end
    end

    // hardware lines 9:2, bit 10 and the ipi bit are not wired here
    assign estat_is = {1'b0, timer_irq, 9'b0, swi};

    assign has_int = (|(estat_is[11:0] & ecfg_lie[11:0])) & crmd_ie;

endmodule

//--- hw/timer_unit.sv
`timescale 1ns/1ps

module timer_unit
    import csr_map_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  csr_access_t access,
    output logic        tcfg_en,
    output logic        tcfg_periodic,
    output logic [29:0] tcfg_initval,
    output csr_word_t   tval,
    output logic        timer_irq
);

    logic      we_tcfg;
    logic      ticlr_clr;
    logic      cnt_zero;
    csr_word_t tcfg_next;

    assign we_tcfg = access.we && (access.num == CSR_TCFG);
    assign ticlr_clr = access.we && (access.num == CSR_TICLR)
                     && access.wmask[TICLR_CLR] && access.wvalue[TICLR_CLR];

    assign tcfg_next = csr_masked({tcfg_initval, tcfg_periodic, tcfg_en},
                                  access.wmask, access.wvalue);
    assign cnt_zero = (tval == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (we_tcfg) begin
            tcfg_en       <= tcfg_next[TCFG_EN];
            tcfg_periodic <= tcfg_next[TCFG_PERIODIC];
            tcfg_initval  <= tcfg_next[TCFG_INITVAL_HI:TCFG_INITVAL_LO];
        end
    end

    // one-shot count runs through zero and then parks at all ones
    always_ff @(posedge clk) begin
        if (reset) begin
            tval <= TIMER_IDLE;
        end else if (we_tcfg && tcfg_next[TCFG_EN]) begin
            tval <= {tcfg_next[TCFG_INITVAL_HI:TCFG_INITVAL_LO], 2'b0};
        end else if (tcfg_en && (tval != TIMER_IDLE)) begin
            if (cnt_zero && tcfg_periodic) begin
                tval <= {tcfg_initval, 2'b0};
            end else begin
                tval <= tval - 32'd1;
            end
        end
    end

    // a zero count beats a clear on the same edge
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_irq <= 1'b0;
        end else if (cnt_zero) begin
            timer_irq <= 1'b1;
        end else if (ticlr_clr) begin
            timer_irq <= 1'b0;
        end
    end

endmodule

//--- hw/exc_state_regs.sv
`timescale 1ns/1ps

module exc_state_regs
    import csr_map_pkg::*;
    import exc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  csr_access_t access,
    input  logic        ertn_flush,
    input  wb_exc_t     wb_exc,
    output logic [1:0]  crmd_plv,
    output logic [1:0]  prmd_pplv,
    output logic        crmd_ie,
    output logic        prmd_pie,
    output logic [5:0]  crmd_mode,
    output csr_word_t   era,
    output csr_word_t   badv,
    output logic [25:0] eentry_va,
    output ecode_t      estat_ecode,
    output esubcode_t   estat_esubcode
);

    logic      we_crmd;
    logic      we_prmd;
    logic      we_era;
    logic      we_eentry;
    logic      addr_err;
    logic      badv_from_pc;
    csr_word_t crmd_next;
    csr_word_t prmd_next;
    csr_word_t era_next;
    csr_word_t eentry_next;

    assign we_crmd   = access.we && (access.num == CSR_CRMD);
    assign we_prmd   = access.we && (access.num == CSR_PRMD);
    assign we_era    = access.we && (access.num == CSR_ERA);
    assign we_eentry = access.we && (access.num == CSR_EENTRY);

    assign crmd_next = csr_masked({23'b0, crmd_mode, crmd_ie, crmd_plv},
                                  access.wmask, access.wvalue);
    assign prmd_next = csr_masked({29'b0, prmd_pie, prmd_pplv},
                                  access.wmask, access.wvalue);
    assign era_next = csr_masked(era, access.wmask, access.wvalue);
    assign eentry_next = csr_masked({eentry_va, 6'b0}, access.wmask, access.wvalue);

    // only address faults carry a bad address
    assign addr_err = (wb_exc.ecode == ECODE_ALE) || (wb_exc.ecode == ECODE_ADEF);
    assign badv_from_pc = (wb_exc.ecode == ECODE_ADEF) && (wb_exc.esubcode == ESUBCODE_ADEF);

    // exception wins over ertn, ertn over a csr write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv  <= 2'b0;
            crmd_ie   <= 1'b0;
            crmd_mode <= CRMD_MODE_RESET;
            prmd_pplv <= 2'b0;
            prmd_pie  <= 1'b0;
        end else if (wb_exc.ex) begin
            crmd_plv  <= 2'b0;
            crmd_ie   <= 1'b0;
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else begin
            if (we_crmd) begin
                crmd_plv  <= crmd_next[CRMD_PLV_HI:CRMD_PLV_LO];
                crmd_ie   <= crmd_next[CRMD_IE];
                crmd_mode <= crmd_next[CRMD_MODE_HI:CRMD_MODE_LO];
            end
            if (we_prmd) begin
                prmd_pplv <= prmd_next[PRMD_PPLV_HI:PRMD_PPLV_LO];
                prmd_pie  <= prmd_next[PRMD_PIE];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            era            <= '0;
            badv           <= '0;
            eentry_va      <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else if (wb_exc.ex) begin
            era            <= wb_exc.pc;
            estat_ecode    <= wb_exc.ecode;
            estat_esubcode <= wb_exc.esubcode;
            if (addr_err) begin
                badv <= badv_from_pc ? wb_exc.pc : wb_exc.vaddr;
            end
        end else if (!ertn_flush) begin
            if (we_era) begin
                era <= era_next;
            end
            if (we_eentry) begin
                eentry_va <= eentry_next[31:EENTRY_VA_LO];
            end
        end
    end

endmodule

//--- hw/exc_pkg.sv
package exc_pkg;

    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;

    localparam ecode_t    ECODE_ADEF    = 6'h08;
    localparam ecode_t    ECODE_ALE     = 6'h09;
    localparam esubcode_t ESUBCODE_ADEF = 9'h000;

    // exception report from write-back, valid while ex is high
    typedef struct packed {
        logic        ex;
        ecode_t      ecode;
        esubcode_t   esubcode;
        logic [31:0] vaddr;
        logic [31:0] pc;
    } wb_exc_t;

endpackage

//--- hw/csr_map_pkg.sv
package csr_map_pkg;

    typedef logic [31:0] csr_word_t;
    typedef logic [13:0] csr_num_t;

    // one CSR access as issued by the pipeline
    typedef struct packed {
        logic      we;
        csr_num_t  num;
        csr_word_t wmask;
        csr_word_t wvalue;
    } csr_access_t;

    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ECFG   = 14'h004;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_BADV   = 14'h007;
    localparam csr_num_t CSR_EENTRY = 14'h00c;
    localparam csr_num_t CSR_TCFG   = 14'h041;
    localparam csr_num_t CSR_TVAL   = 14'h042;
    localparam csr_num_t CSR_TICLR  = 14'h044;

    // crmd: mode holds DA, PG, DATF, DATM from bit 3 upwards
    localparam int CRMD_PLV_LO  = 0;
    localparam int CRMD_PLV_HI  = 1;
    localparam int CRMD_IE      = 2;
    localparam int CRMD_MODE_LO = 3;
    localparam int CRMD_MODE_HI = 8;

    localparam logic [5:0] CRMD_MODE_RESET = 6'b000001;

    localparam int PRMD_PPLV_LO = 0;
    localparam int PRMD_PPLV_HI = 1;
    localparam int PRMD_PIE     = 2;

    localparam int ESTAT_IS_HI       = 12;
    localparam int ESTAT_SWI_LO      = 0;
    localparam int ESTAT_SWI_HI      = 1;
    localparam int ESTAT_ECODE_LO    = 16;
    localparam int ESTAT_ECODE_HI    = 21;
    localparam int ESTAT_ESUBCODE_LO = 22;
    localparam int ESTAT_ESUBCODE_HI = 30;

    localparam int ECFG_LIE_HI  = 12;
    localparam int EENTRY_VA_LO = 6;

    localparam int TCFG_EN         = 0;
    localparam int TCFG_PERIODIC   = 1;
    localparam int TCFG_INITVAL_LO = 2;
    localparam int TCFG_INITVAL_HI = 31;

    localparam int TICLR_CLR = 0;

    // lie bit 10 has no interrupt source behind it
    localparam logic [12:0] ECFG_LIE_WRITABLE = 13'h1bff;

    localparam csr_word_t TIMER_IDLE = 32'hffff_ffff;

    // bits under the mask take the new value, the rest keep the old
    function automatic csr_word_t csr_masked(input csr_word_t old_word,
                                             input csr_word_t mask,
                                             input csr_word_t value);
        return (mask & value) | (~mask & old_word);
    endfunction

endpackage
